// ==== hdl/csr_pkg.sv ====
package csr_pkg;

    localparam int XLEN = 64;

    typedef logic [11:0]     csr_addr_t;
    typedef logic [XLEN-1:0] csr_data_t;

    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MEDELEG  = 12'h302;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_SSTATUS  = 12'h100;
    localparam csr_addr_t CSR_STVEC    = 12'h105;
    localparam csr_addr_t CSR_SSCRATCH = 12'h140;
    localparam csr_addr_t CSR_SEPC     = 12'h141;
    localparam csr_addr_t CSR_SCAUSE   = 12'h142;
    localparam csr_addr_t CSR_STVAL    = 12'h143;
    localparam csr_addr_t CSR_MCYCLE   = 12'hb00;
    localparam csr_addr_t CSR_MINSTRET = 12'hb02;
    localparam csr_addr_t CSR_CYCLE    = 12'hc00; // user alias of mcycle

    localparam int MSTATUS_SIE_BIT  = 1;
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_SPIE_BIT = 5;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_SPP_BIT  = 8;
    localparam int MSTATUS_MPP_LSB  = 11; // two bits
    localparam int MSTATUS_SUM_BIT  = 18;
    localparam int MSTATUS_MXR_BIT  = 19;

    // fields of mstatus seen through sstatus
    localparam csr_data_t SSTATUS_MASK = (csr_data_t'(1) << MSTATUS_SIE_BIT)
                                       | (csr_data_t'(1) << MSTATUS_SPIE_BIT)
                                       | (csr_data_t'(1) << MSTATUS_SPP_BIT)
                                       | (csr_data_t'(1) << MSTATUS_SUM_BIT)
                                       | (csr_data_t'(1) << MSTATUS_MXR_BIT);

    localparam int MEDELEG_WIDTH = 16; // delegable exception codes

endpackage

// ==== hdl/priv_pkg.sv ====
package priv_pkg;

    typedef logic [1:0] priv_mode_t;

    localparam priv_mode_t PRIV_U = 2'd0;
    localparam priv_mode_t PRIV_S = 2'd1;
    localparam priv_mode_t PRIV_M = 2'd3;

    localparam int CAUSE_WIDTH = 5; // msb flags an interrupt

    typedef logic [CAUSE_WIDTH-2:0] excp_code_t;

    localparam excp_code_t CAUSE_INSTR_ACCESS_FAULT = 4'd1;
    localparam excp_code_t CAUSE_LOAD_ACCESS_FAULT  = 4'd5;
    localparam excp_code_t CAUSE_STORE_ACCESS_FAULT = 4'd7;
    localparam excp_code_t CAUSE_INSTR_PAGE_FAULT   = 4'd12;
    localparam excp_code_t CAUSE_LOAD_PAGE_FAULT    = 4'd13;
    localparam excp_code_t CAUSE_STORE_PAGE_FAULT   = 4'd15;

    // faults that report the offending address in xtval
    function automatic logic tval_cause(excp_code_t code);
        case (code)
            CAUSE_INSTR_ACCESS_FAULT, CAUSE_LOAD_ACCESS_FAULT, CAUSE_STORE_ACCESS_FAULT,
            CAUSE_INSTR_PAGE_FAULT, CAUSE_LOAD_PAGE_FAULT, CAUSE_STORE_PAGE_FAULT:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

endpackage

// ==== hdl/csr_state_if.sv ====
`timescale 1ns/1ps

interface csr_state_if
    import csr_pkg::*, priv_pkg::*;
#(
    parameter int PC_WIDTH = 39
) ();

    logic                     take_m_trap;
    logic                     take_s_trap;
    logic                     do_mret;
    logic                     do_sret;
    priv_mode_t               next_mode;
    priv_mode_t               cur_mode;

    logic                     mie;
    logic                     mpie;
    priv_mode_t               mpp;
    logic                     sie;
    logic                     spie;
    logic                     spp;
    logic                     sum;
    logic                     mxr;

    csr_data_t                mtvec;
    csr_data_t                stvec;
    logic [PC_WIDTH-1:0]      mepc; // sign-extended when read
    logic [PC_WIDTH-1:0]      sepc;
    csr_data_t                mscratch;
    csr_data_t                sscratch;
    csr_data_t                mtval;
    csr_data_t                stval;
    csr_data_t                mcause;
    csr_data_t                scause;
    logic [MEDELEG_WIDTH-1:0] medeleg;
    csr_data_t                mcycle;
    csr_data_t                minstret;

    modport ctrl_mp (
        output take_m_trap, take_s_trap, do_mret, do_sret, next_mode,
        input  cur_mode, mpp, spp, mtvec, stvec, mepc, sepc, medeleg
    );

    modport state_mp (
        input  take_m_trap, take_s_trap, do_mret, do_sret, next_mode,
        output cur_mode, mie, mpie, mpp, sie, spie, spp, sum, mxr,
        output mtvec, stvec, mepc, sepc, mscratch, sscratch, mtval, stval,
        output mcause, scause, medeleg, mcycle, minstret
    );

    modport read_mp (
        input mie, mpie, mpp, sie, spie, spp, sum, mxr,
        input mtvec, stvec, mepc, sepc, mscratch, sscratch, mtval, stval,
        input mcause, scause, medeleg, mcycle, minstret
    );

endinterface

// ==== hdl/csr_trap_ctrl.sv ====
`timescale 1ns/1ps

module csr_trap_ctrl
    import priv_pkg::*, csr_pkg::*;
#(
    parameter int PC_WIDTH = 39
) (
    input  logic                   excp_valid_i,
    input  logic [CAUSE_WIDTH-1:0] excp_cause_i,
    input  logic                   mret_i,
    input  logic                   sret_i,
    csr_state_if.ctrl_mp           bus,
    output logic [PC_WIDTH-1:0]    redirect_pc_o
);

    excp_code_t code;
    logic       deleg;
    csr_data_t  tvec;

    assign code  = excp_cause_i[CAUSE_WIDTH-2:0];
    assign deleg = bus.medeleg[code]; // one medeleg bit per exception code

    // exception first, then mret over sret
    always_comb begin
        bus.take_m_trap = 1'b0;
        bus.take_s_trap = 1'b0;
        bus.do_mret     = 1'b0;
        bus.do_sret     = 1'b0;
        bus.next_mode   = bus.cur_mode;
        if (excp_valid_i) begin
            if (deleg) begin
                bus.take_s_trap = 1'b1;
                bus.next_mode   = PRIV_S;
            end else begin
                bus.take_m_trap = 1'b1;
                bus.next_mode   = PRIV_M;
            end
        end else if (mret_i) begin
            bus.do_mret   = 1'b1;
            bus.next_mode = bus.mpp;
        end else if (sret_i) begin
            bus.do_sret   = 1'b1;
            bus.next_mode = {1'b0, bus.spp}; // U or S
        end
    end

    assign tvec = bus.take_s_trap ? bus.stvec : bus.mtvec;

    always_comb begin
        if (bus.do_mret) begin
            redirect_pc_o = bus.mepc;
        end else if (bus.do_sret) begin
            redirect_pc_o = bus.sepc;
        end else begin
            redirect_pc_o = {tvec[PC_WIDTH-1:2], 2'b00}; // direct mode only
        end
    end

    // xret targets come from the stored epc
    a_xret_aligned: assert final (!(bus.do_mret || bus.do_sret) || redirect_pc_o[0] === 1'b0)
        else $error("xret redirect pc is not 2-byte aligned");

    // relies on the state block never holding MPP = 2
    a_next_mode_legal: assert final (bus.next_mode !== 2'd2)
        else $error("next_mode is the reserved mode 2");

endmodule

// ==== hdl/csr_state.sv ====
`timescale 1ns/1ps

module csr_state
    import csr_pkg::*, priv_pkg::*;
#(
    parameter int PC_WIDTH = 39
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   csr_we_i,
    input  csr_addr_t              csr_waddr_i,
    input  csr_data_t              csr_wdata_i,
    input  logic                   excp_valid_i,
    input  logic [CAUSE_WIDTH-1:0] excp_cause_i,
    input  csr_data_t              excp_tval_i,
    input  logic [PC_WIDTH-1:0]    excp_pc_i,
    input  logic                   commit_first_i,
    input  logic                   commit_second_i,
    csr_state_if.state_mp          bus
);

    logic                wr_en;
    logic [PC_WIDTH-1:0] wr_epc;
    logic [PC_WIDTH-1:0] trap_epc;
    excp_code_t          trap_code;
    logic [1:0]          commit_cnt;

    // interrupt flag in the msb, code in the low bits
    function automatic csr_data_t pack_cause(logic irq, excp_code_t code);
        return {irq, {(XLEN-CAUSE_WIDTH){1'b0}}, code};
    endfunction

    assign wr_en      = csr_we_i & ~excp_valid_i; // exception wins over a write
    assign wr_epc     = {csr_wdata_i[PC_WIDTH-1:1], 1'b0};
    assign trap_epc   = {excp_pc_i[PC_WIDTH-1:1], 1'b0};
    assign trap_code  = excp_cause_i[CAUSE_WIDTH-2:0];
    assign commit_cnt = {1'b0, commit_first_i} + {1'b0, commit_second_i};

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.cur_mode <= PRIV_M;
            bus.mpp      <= PRIV_M;
            bus.mie      <= 1'b0;
            bus.mpie     <= 1'b0;
            bus.sie      <= 1'b0;
            bus.spie     <= 1'b0;
            bus.spp      <= 1'b0;
            bus.sum      <= 1'b0;
            bus.mxr      <= 1'b0;
            bus.medeleg  <= '0;
            bus.mtvec    <= '0;
            bus.stvec    <= '0;
            bus.mepc     <= '0;
            bus.sepc     <= '0;
            bus.mscratch <= '0;
            bus.sscratch <= '0;
            bus.mtval    <= '0;
            bus.stval    <= '0;
            bus.mcause   <= '0;
            bus.scause   <= '0;
        end else begin
            if (wr_en) begin
                case (csr_waddr_i)
                    CSR_MSTATUS: begin
                        bus.sie  <= csr_wdata_i[MSTATUS_SIE_BIT];
                        bus.mie  <= csr_wdata_i[MSTATUS_MIE_BIT];
                        bus.spie <= csr_wdata_i[MSTATUS_SPIE_BIT];
                        bus.mpie <= csr_wdata_i[MSTATUS_MPIE_BIT];
                        bus.spp  <= csr_wdata_i[MSTATUS_SPP_BIT];
                        bus.sum  <= csr_wdata_i[MSTATUS_SUM_BIT];
                        bus.mxr  <= csr_wdata_i[MSTATUS_MXR_BIT];
                        if (csr_wdata_i[MSTATUS_MPP_LSB +: 2] != 2'd2) begin
                            bus.mpp <= csr_wdata_i[MSTATUS_MPP_LSB +: 2]; // 2 is reserved
                        end
                    end
                    CSR_SSTATUS: begin // only the sstatus fields
                        bus.sie  <= csr_wdata_i[MSTATUS_SIE_BIT];
                        bus.spie <= csr_wdata_i[MSTATUS_SPIE_BIT];
                        bus.spp  <= csr_wdata_i[MSTATUS_SPP_BIT];
                        bus.sum  <= csr_wdata_i[MSTATUS_SUM_BIT];
                        bus.mxr  <= csr_wdata_i[MSTATUS_MXR_BIT];
                    end
                    CSR_MEDELEG:  bus.medeleg  <= csr_wdata_i[MEDELEG_WIDTH-1:0];
                    CSR_MTVEC:    bus.mtvec    <= csr_wdata_i;
                    CSR_STVEC:    bus.stvec    <= csr_wdata_i;
                    CSR_MSCRATCH: bus.mscratch <= csr_wdata_i;
                    CSR_SSCRATCH: bus.sscratch <= csr_wdata_i;
                    CSR_MEPC:     bus.mepc     <= wr_epc;
                    CSR_SEPC:     bus.sepc     <= wr_epc;
                    CSR_MTVAL:    bus.mtval    <= csr_wdata_i;
                    CSR_STVAL:    bus.stval    <= csr_wdata_i;
                    CSR_MCAUSE:   bus.mcause   <= pack_cause(csr_wdata_i[XLEN-1],
                                                             csr_wdata_i[CAUSE_WIDTH-2:0]);
                    CSR_SCAUSE:   bus.scause   <= pack_cause(csr_wdata_i[XLEN-1],
                                                             csr_wdata_i[CAUSE_WIDTH-2:0]);
                    default: ;
                endcase
            end
            // trap and xret override overlapping write fields
            if (bus.take_m_trap) begin
                bus.mepc   <= trap_epc;
                bus.mcause <= pack_cause(excp_cause_i[CAUSE_WIDTH-1], trap_code);
                bus.mtval  <= '0;
                bus.mpie   <= bus.mie;
                bus.mie    <= 1'b0;
                bus.mpp    <= bus.cur_mode;
            end else if (bus.take_s_trap) begin
                bus.sepc   <= trap_epc;
                bus.scause <= pack_cause(excp_cause_i[CAUSE_WIDTH-1], trap_code);
                bus.stval  <= tval_cause(trap_code) ? excp_tval_i : '0;
                bus.spie   <= bus.sie;
                bus.sie    <= 1'b0;
                bus.spp    <= bus.cur_mode[0];
            end else if (bus.do_mret) begin
                bus.mie  <= bus.mpie;
                bus.mpie <= 1'b1;
                bus.mpp  <= PRIV_U;
            end else if (bus.do_sret) begin
                bus.sie  <= bus.spie;
                bus.spie <= 1'b1;
                bus.spp  <= 1'b0;
            end
            if (bus.take_m_trap | bus.take_s_trap | bus.do_mret | bus.do_sret) begin
                bus.cur_mode <= bus.next_mode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.mcycle   <= '0;
            bus.minstret <= '0;
        end else begin
            if (wr_en && csr_waddr_i == CSR_MCYCLE) begin
                bus.mcycle <= csr_wdata_i; // load replaces this cycle's increment
            end else begin
                bus.mcycle <= bus.mcycle + 1'b1;
            end
            if (wr_en && csr_waddr_i == CSR_MINSTRET) begin
                bus.minstret <= csr_wdata_i;
            end else begin
                bus.minstret <= bus.minstret + csr_data_t'(commit_cnt);
            end
        end
    end

    a_strobes_follow_excp: assert property (@(posedge clk) disable iff (rst)
        (bus.take_m_trap | bus.take_s_trap) == excp_valid_i
        && !((bus.do_mret | bus.do_sret) && excp_valid_i));

    a_mode_legal: assert property (@(posedge clk) disable iff (rst)
        bus.cur_mode !== 2'd2);

endmodule

// ==== hdl/csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux
    import csr_pkg::*;
(
    input  csr_addr_t       csr_raddr_i,
    csr_state_if.read_mp    bus,
    output csr_data_t       rdata_o,
    output logic            readable_o,
    output logic            writeable_o,
    output csr_data_t       mstatus_o
);

    csr_data_t sstatus;

    always_comb begin
        mstatus_o                        = '0;
        mstatus_o[MSTATUS_SIE_BIT]       = bus.sie;
        mstatus_o[MSTATUS_MIE_BIT]       = bus.mie;
        mstatus_o[MSTATUS_SPIE_BIT]      = bus.spie;
        mstatus_o[MSTATUS_MPIE_BIT]      = bus.mpie;
        mstatus_o[MSTATUS_SPP_BIT]       = bus.spp;
        mstatus_o[MSTATUS_MPP_LSB +: 2]  = bus.mpp;
        mstatus_o[MSTATUS_SUM_BIT]       = bus.sum;
        mstatus_o[MSTATUS_MXR_BIT]       = bus.mxr;
    end

    assign sstatus = mstatus_o & SSTATUS_MASK;

    always_comb begin
        rdata_o     = '0;
        readable_o  = 1'b1;
        writeable_o = 1'b1;
        case (csr_raddr_i)
            CSR_MSTATUS:  rdata_o = mstatus_o;
            CSR_SSTATUS:  rdata_o = sstatus;
            CSR_MEDELEG:  rdata_o = csr_data_t'(bus.medeleg);
            CSR_MTVEC:    rdata_o = bus.mtvec;
            CSR_STVEC:    rdata_o = bus.stvec;
            CSR_MSCRATCH: rdata_o = bus.mscratch;
            CSR_SSCRATCH: rdata_o = bus.sscratch;
            CSR_MEPC:     rdata_o = csr_data_t'(signed'(bus.mepc)); // sign-extend from pc width
            CSR_SEPC:     rdata_o = csr_data_t'(signed'(bus.sepc));
            CSR_MCAUSE:   rdata_o = bus.mcause;
            CSR_SCAUSE:   rdata_o = bus.scause;
            CSR_MTVAL:    rdata_o = bus.mtval;
            CSR_STVAL:    rdata_o = bus.stval;
            CSR_MCYCLE:   rdata_o = bus.mcycle;
            CSR_MINSTRET: rdata_o = bus.minstret;
            CSR_CYCLE: begin
                rdata_o     = bus.mcycle;
                writeable_o = 1'b0; // read-only alias
            end
            default: begin
                readable_o  = 1'b0;
                writeable_o = 1'b0;
            end
        endcase
    end

endmodule

// ==== hdl/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit
    import csr_pkg::*, priv_pkg::*;
#(
    parameter int PC_WIDTH = 39
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   csr_we_i,
    input  csr_addr_t              csr_waddr_i,
    input  csr_addr_t              csr_raddr_i,
    input  csr_data_t              csr_wdata_i,
    input  logic                   excp_valid_i,
    input  logic [CAUSE_WIDTH-1:0] excp_cause_i,
    input  csr_data_t              excp_tval_i,
    input  logic [PC_WIDTH-1:0]    excp_pc_i,
    input  logic                   mret_i,
    input  logic                   sret_i,
    input  logic                   commit_first_i,
    input  logic                   commit_second_i,
    output csr_data_t              rdata_o,
    output logic                   readable_o,
    output logic                   writeable_o,
    output logic [PC_WIDTH-1:0]    redirect_pc_o,
    output priv_mode_t             priv_mode_o,
    output csr_data_t              mstatus_o
);

    csr_state_if #(.PC_WIDTH(PC_WIDTH)) st_if ();

    csr_trap_ctrl #(.PC_WIDTH(PC_WIDTH)) u_trap_ctrl (
        .excp_valid_i  (excp_valid_i),
        .excp_cause_i  (excp_cause_i),
        .mret_i        (mret_i),
        .sret_i        (sret_i),
        .bus           (st_if.ctrl_mp),
        .redirect_pc_o (redirect_pc_o)
    );

    csr_state #(.PC_WIDTH(PC_WIDTH)) u_state (
        .clk             (clk),
        .rst             (rst),
        .csr_we_i        (csr_we_i),
        .csr_waddr_i     (csr_waddr_i),
        .csr_wdata_i     (csr_wdata_i),
        .excp_valid_i    (excp_valid_i),
        .excp_cause_i    (excp_cause_i),
        .excp_tval_i     (excp_tval_i),
        .excp_pc_i       (excp_pc_i),
        .commit_first_i  (commit_first_i),
        .commit_second_i (commit_second_i),
        .bus             (st_if.state_mp)
    );

    csr_read_mux u_read_mux (
        .csr_raddr_i (csr_raddr_i),
        .bus         (st_if.read_mp),
        .rdata_o     (rdata_o),
        .readable_o  (readable_o),
        .writeable_o (writeable_o),
        .mstatus_o   (mstatus_o)
    );

    assign priv_mode_o = st_if.cur_mode; // to decode

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 5 // 10 ns period
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

endmodule

// ==== sim/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb
    import csr_pkg::*, priv_pkg::*;
();

    localparam int PC_WIDTH = 39;

    logic                   clk;
    logic                   rst;
    logic                   csr_we;
    csr_addr_t              csr_waddr;
    csr_addr_t              csr_raddr;
    csr_data_t              csr_wdata;
    logic                   excp_valid;
    logic [CAUSE_WIDTH-1:0] excp_cause;
    csr_data_t              excp_tval;
    logic [PC_WIDTH-1:0]    excp_pc;
    logic                   mret;
    logic                   sret;
    logic                   commit_first;
    logic                   commit_second;
    csr_data_t              rdata;
    logic                   readable;
    logic                   writeable;
    logic [PC_WIDTH-1:0]    redirect_pc;
    priv_mode_t             priv_mode;
    csr_data_t              mstatus;

    string       test_name  = "reset";
    int          errors     = 0;
    int          timeouts   = 0;
    int          checks     = 0;
    logic [31:0] rand_state = 32'h21cf_628e;
    csr_addr_t   wr_list[$];

    // shadow copies of the architectural state
    priv_mode_t       mdl_mode, mdl_mpp;
    logic             mdl_mie, mdl_mpie, mdl_sie, mdl_spie, mdl_spp, mdl_sum, mdl_mxr;
    logic [15:0]      mdl_medeleg;
    csr_data_t        mdl_mtvec, mdl_stvec, mdl_mepc, mdl_sepc, mdl_mscratch, mdl_sscratch;
    csr_data_t        mdl_mtval, mdl_stval, mdl_mcause, mdl_scause, mdl_mcycle, mdl_minstret;

    tb_clock #(.HALF_PERIOD_NS(5)) u_clock (.clk_o(clk));

    csr_unit #(.PC_WIDTH(PC_WIDTH)) csr_unit_i (
        .clk(clk), .rst(rst), .csr_we_i(csr_we), .csr_waddr_i(csr_waddr),
        .csr_raddr_i(csr_raddr), .csr_wdata_i(csr_wdata), .excp_valid_i(excp_valid),
        .excp_cause_i(excp_cause), .excp_tval_i(excp_tval), .excp_pc_i(excp_pc),
        .mret_i(mret), .sret_i(sret), .commit_first_i(commit_first),
        .commit_second_i(commit_second), .rdata_o(rdata), .readable_o(readable),
        .writeable_o(writeable), .redirect_pc_o(redirect_pc), .priv_mode_o(priv_mode),
        .mstatus_o(mstatus)
    );

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic csr_data_t rnd64();
        return {lcg_next(), lcg_next()};
    endfunction

    // aligned to 2 bytes, sign-extended from the pc width
    function automatic csr_data_t epc_word(csr_data_t pc);
        logic [PC_WIDTH-1:0] p;
        p = {pc[PC_WIDTH-1:1], 1'b0};
        return {{(XLEN-PC_WIDTH){p[PC_WIDTH-1]}}, p};
    endfunction

    function automatic csr_data_t cause_word(logic irq, logic [3:0] code);
        return {irq, {(XLEN-5){1'b0}}, code};
    endfunction

    function automatic logic tval_kept(logic [3:0] code);
        case (code)
            4'd1, 4'd5, 4'd7, 4'd12, 4'd13, 4'd15: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic csr_data_t mstatus_word();
        csr_data_t w;
        w = '0;
        w[MSTATUS_SIE_BIT]      = mdl_sie;
        w[MSTATUS_MIE_BIT]      = mdl_mie;
        w[MSTATUS_SPIE_BIT]     = mdl_spie;
        w[MSTATUS_MPIE_BIT]     = mdl_mpie;
        w[MSTATUS_SPP_BIT]      = mdl_spp;
        w[MSTATUS_MPP_LSB +: 2] = mdl_mpp;
        w[MSTATUS_SUM_BIT]      = mdl_sum;
        w[MSTATUS_MXR_BIT]      = mdl_mxr;
        return w;
    endfunction

    function automatic logic known_addr(csr_addr_t a);
        case (a)
            CSR_MSTATUS, CSR_MEDELEG, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
            CSR_MTVAL, CSR_SSTATUS, CSR_STVEC, CSR_SSCRATCH, CSR_SEPC, CSR_SCAUSE,
            CSR_STVAL, CSR_MCYCLE, CSR_MINSTRET, CSR_CYCLE: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic csr_data_t exp_read(csr_addr_t a);
        case (a)
            CSR_MSTATUS:  return mstatus_word();
            CSR_SSTATUS:  return mstatus_word() & SSTATUS_MASK;
            CSR_MEDELEG:  return csr_data_t'(mdl_medeleg);
            CSR_MTVEC:    return mdl_mtvec;
            CSR_STVEC:    return mdl_stvec;
            CSR_MSCRATCH: return mdl_mscratch;
            CSR_SSCRATCH: return mdl_sscratch;
            CSR_MEPC:     return mdl_mepc;
            CSR_SEPC:     return mdl_sepc;
            CSR_MCAUSE:   return mdl_mcause;
            CSR_SCAUSE:   return mdl_scause;
            CSR_MTVAL:    return mdl_mtval;
            CSR_STVAL:    return mdl_stval;
            CSR_MINSTRET: return mdl_minstret;
            CSR_MCYCLE, CSR_CYCLE: return mdl_mcycle;
            default:      return '0;
        endcase
    endfunction

    function automatic logic [PC_WIDTH-1:0] exp_redirect(logic ex, logic [4:0] c, logic mr);
        csr_data_t tvec;
        tvec = mdl_medeleg[c[3:0]] ? mdl_stvec : mdl_mtvec;
        if (ex) begin
            return {tvec[PC_WIDTH-1:2], 2'b00};
        end else if (mr) begin
            return mdl_mepc[PC_WIDTH-1:0];
        end
        return mdl_sepc[PC_WIDTH-1:0];
    endfunction

    function automatic void ref_reset();
        mdl_mode = PRIV_M;
        mdl_mpp  = PRIV_M;
        {mdl_mie, mdl_mpie, mdl_sie, mdl_spie, mdl_spp, mdl_sum, mdl_mxr} = '0;
        mdl_medeleg = '0;
        {mdl_mtvec, mdl_stvec, mdl_mepc, mdl_sepc, mdl_mscratch, mdl_sscratch} = '0;
        {mdl_mtval, mdl_stval, mdl_mcause, mdl_scause, mdl_mcycle, mdl_minstret} = '0;
    endfunction

    // one clock edge of the CSR rules
    function automatic void ref_csr(logic we, csr_addr_t a, csr_data_t w, logic ex,
                                    logic [4:0] c, csr_data_t tv, csr_data_t pc,
                                    logic mr, logic sr, logic c1, logic c2);
        logic       wr;
        logic       deleg;
        logic       o_mie, o_mpie, o_sie, o_spie, o_spp;
        priv_mode_t o_mpp, o_mode;
        wr    = we && !ex;
        deleg = mdl_medeleg[c[3:0]];
        {o_mie, o_mpie, o_sie, o_spie, o_spp} = {mdl_mie, mdl_mpie, mdl_sie, mdl_spie, mdl_spp};
        o_mpp  = mdl_mpp;
        o_mode = mdl_mode;
        if (wr) begin
            case (a)
                CSR_MSTATUS, CSR_SSTATUS: begin
                    mdl_sie  = w[MSTATUS_SIE_BIT];
                    mdl_spie = w[MSTATUS_SPIE_BIT];
                    mdl_spp  = w[MSTATUS_SPP_BIT];
                    mdl_sum  = w[MSTATUS_SUM_BIT];
                    mdl_mxr  = w[MSTATUS_MXR_BIT];
                    if (a == CSR_MSTATUS) begin
                        mdl_mie  = w[MSTATUS_MIE_BIT];
                        mdl_mpie = w[MSTATUS_MPIE_BIT];
                        if (w[MSTATUS_MPP_LSB +: 2] != 2'd2) begin
                            mdl_mpp = w[MSTATUS_MPP_LSB +: 2]; // mode 2 reserved
                        end
                    end
                end
                CSR_MEDELEG:  mdl_medeleg  = w[15:0];
                CSR_MTVEC:    mdl_mtvec    = w;
                CSR_STVEC:    mdl_stvec    = w;
                CSR_MSCRATCH: mdl_mscratch = w;
                CSR_SSCRATCH: mdl_sscratch = w;
                CSR_MEPC:     mdl_mepc     = epc_word(w);
                CSR_SEPC:     mdl_sepc     = epc_word(w);
                CSR_MTVAL:    mdl_mtval    = w;
                CSR_STVAL:    mdl_stval    = w;
                CSR_MCAUSE:   mdl_mcause   = cause_word(w[XLEN-1], w[3:0]);
                CSR_SCAUSE:   mdl_scause   = cause_word(w[XLEN-1], w[3:0]);
                default: ;
            endcase
        end
        mdl_mcycle   = (wr && a == CSR_MCYCLE) ? w : mdl_mcycle + 1;
        mdl_minstret = (wr && a == CSR_MINSTRET) ? w : mdl_minstret + c1 + c2;
        if (ex && !deleg) begin
            mdl_mepc   = epc_word(pc);
            mdl_mcause = cause_word(c[4], c[3:0]);
            mdl_mtval  = '0;
            mdl_mpie   = o_mie;
            mdl_mie    = 1'b0;
            mdl_mpp    = o_mode;
            mdl_mode   = PRIV_M;
        end else if (ex) begin
            mdl_sepc   = epc_word(pc);
            mdl_scause = cause_word(c[4], c[3:0]);
            mdl_stval  = tval_kept(c[3:0]) ? tv : '0;
            mdl_spie   = o_sie;
            mdl_sie    = 1'b0;
            mdl_spp    = o_mode[0];
            mdl_mode   = PRIV_S;
        end else if (mr) begin
            mdl_mie  = o_mpie;
            mdl_mpie = 1'b1;
            mdl_mpp  = PRIV_U;
            mdl_mode = o_mpp;
        end else if (sr) begin
            mdl_sie  = o_spie;
            mdl_spie = 1'b1;
            mdl_spp  = 1'b0;
            mdl_mode = {1'b0, o_spp};
        end
    endfunction

    task automatic check_val(string what, csr_data_t exp, csr_data_t act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // inputs are stable around the rising edge, registers update after it
    always @(posedge clk) begin
        if (rst) begin
            ref_reset();
        end else begin
            check_val("rdata", exp_read(csr_raddr), rdata);
            check_val("readable", known_addr(csr_raddr), readable);
            check_val("writeable", known_addr(csr_raddr) && csr_raddr != CSR_CYCLE, writeable);
            check_val("mode", mdl_mode, priv_mode);
            check_val("mstatus", mstatus_word(), mstatus);
            if (excp_valid || mret || sret) begin
                check_val("redirect", exp_redirect(excp_valid, excp_cause, mret), redirect_pc);
            end
            ref_csr(csr_we, csr_waddr, csr_wdata, excp_valid, excp_cause, excp_tval,
                    csr_data_t'(excp_pc), mret, sret, commit_first, commit_second);
        end
    end

    task automatic tick();
        @(negedge clk);
        csr_we        = 1'b0; // strobes last one cycle
        excp_valid    = 1'b0;
        mret          = 1'b0;
        sret          = 1'b0;
        commit_first  = 1'b0;
        commit_second = 1'b0;
    endtask

    task automatic write_csr(csr_addr_t a, csr_data_t d);
        csr_we    = 1'b1;
        csr_waddr = a;
        csr_wdata = d;
        csr_raddr = a;
        tick();
    endtask

    task automatic read_csr(csr_addr_t a);
        csr_raddr = a;
        tick();
    endtask

    task automatic raise(logic [4:0] cause, csr_data_t tval, csr_data_t pc);
        excp_valid = 1'b1;
        excp_cause = cause;
        excp_tval  = tval;
        excp_pc    = pc[PC_WIDTH-1:0];
        tick();
    endtask

    task automatic wait_mode(priv_mode_t m, string what);
        int n;
        n = 0;
        while (priv_mode !== m && n < 5) begin
            tick();
            n++;
        end
        if (priv_mode !== m) begin
            timeouts++;
            $display("timeout: privilege mode did not become %0d after %s", m, what);
        end
    endtask

    initial begin
        #50000;
        $display("simulation ran past its time limit");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        csr_data_t v;
        rst = 1'b1;
        {csr_we, excp_valid, mret, sret, commit_first, commit_second} = '0;
        csr_waddr  = '0;
        csr_raddr  = '0;
        csr_wdata  = '0;
        excp_cause = '0;
        excp_tval  = '0;
        excp_pc    = '0;
        wr_list = '{CSR_MSTATUS, CSR_MEDELEG, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
                    CSR_MTVAL, CSR_SSTATUS, CSR_STVEC, CSR_SSCRATCH, CSR_SEPC, CSR_SCAUSE,
                    CSR_STVAL, CSR_MINSTRET};
        repeat (3) @(negedge clk);
        rst = 1'b0;
        wait_mode(PRIV_M, "reset");

        test_name = "write_read";
        repeat (2) begin
            foreach (wr_list[i]) begin
                write_csr(wr_list[i], rnd64());
                read_csr(wr_list[i]);
            end
        end
        read_csr(CSR_CYCLE);
        read_csr(12'h7c0); // unimplemented address

        test_name = "sstatus";
        write_csr(CSR_MSTATUS, '0);
        write_csr(CSR_SSTATUS, '1);
        read_csr(CSR_MSTATUS);
        write_csr(CSR_SSTATUS, rnd64());
        read_csr(CSR_SSTATUS);

        test_name = "trap_m";
        write_csr(CSR_MEDELEG, '0);
        write_csr(CSR_MTVEC, rnd64());
        write_csr(CSR_MSTATUS, (csr_data_t'(1) << MSTATUS_MIE_BIT)
                             | (csr_data_t'(PRIV_M) << MSTATUS_MPP_LSB));
        raise(5'd5, rnd64(), rnd64());
        read_csr(CSR_MEPC);
        read_csr(CSR_MCAUSE);
        read_csr(CSR_MTVAL);
        read_csr(CSR_MSTATUS);

        test_name = "deleg_mret";
        write_csr(CSR_MEDELEG, csr_data_t'(1) << 13);
        write_csr(CSR_MSTATUS, csr_data_t'(PRIV_S) << MSTATUS_MPP_LSB);
        write_csr(CSR_MEPC, rnd64());
        mret = 1'b1;
        tick();
        wait_mode(PRIV_S, "mret");
        test_name = "trap_s";
        write_csr(CSR_STVEC, rnd64());
        raise(5'd13, rnd64(), rnd64());
        read_csr(CSR_SEPC);
        read_csr(CSR_SCAUSE);
        read_csr(CSR_STVAL);
        read_csr(CSR_SSTATUS);
        test_name = "trap_s_to_m";
        raise(5'd2, rnd64(), rnd64()); // not delegated
        wait_mode(PRIV_M, "undelegated trap");
        read_csr(CSR_MSTATUS);
        test_name = "sret";
        sret = 1'b1;
        tick();
        wait_mode(PRIV_S, "sret");

        test_name = "counters";
        write_csr(CSR_MCYCLE, rnd64());
        repeat (3) read_csr(CSR_MCYCLE);
        read_csr(CSR_CYCLE);
        repeat (10) begin
            v = lcg_next();
            commit_first  = v[20];
            commit_second = v[27];
            csr_raddr     = CSR_MINSTRET;
            tick();
        end
        read_csr(CSR_MINSTRET);

        test_name = "excp_write";
        csr_we    = 1'b1;
        csr_waddr = CSR_MSCRATCH;
        csr_wdata = rnd64();
        raise(5'd2, rnd64(), rnd64());
        read_csr(CSR_MSCRATCH);
        test_name = "excp_mret";
        mret = 1'b1;
        raise(5'd13, rnd64(), rnd64());
        read_csr(CSR_MSTATUS);
        tick();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/csr_pkg.sv
hdl/priv_pkg.sv
hdl/csr_state_if.sv
hdl/csr_trap_ctrl.sv
hdl/csr_state.sv
hdl/csr_read_mux.sv
hdl/csr_unit.sv
sim/tb_clock.sv
sim/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - hdl/csr_pkg.sv
  - hdl/priv_pkg.sv
  - hdl/csr_state_if.sv
  - hdl/csr_trap_ctrl.sv
  - hdl/csr_state.sv
  - hdl/csr_read_mux.sv
  - hdl/csr_unit.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/csr_unit_tb.sv
